// ==== common/dekatron_config.svh ====
`ifndef DEKATRON_CONFIG_SVH
`define DEKATRON_CONFIG_SVH

// number of decade tubes in the register
`define DEK_DIGITS 6

// bits per BCD digit
`define DEK_DIGIT_WIDTH 4

// Clk cycles that Ready stays low for each accepted request, at least 1
`define DEK_COUNT_DELAY 3

// hsClk cycles from a rising Step to the last guide pulse on the bus
`define DEK_STEP_CYCLES 4

// full width of the counter value
`define DEK_WIDTH (`DEK_DIGITS * `DEK_DIGIT_WIDTH)

`endif

// ==== common/dekatron_pkg.sv ====
`include "dekatron_config.svh"

package dekatron_pkg;

	// guide pulse bus, bit 0 is guide A and bit 1 is guide B
	// at most one guide is driven at a time
	typedef logic [1:0] guideT;

	// one BCD digit as held by a single decade tube
	typedef logic [`DEK_DIGIT_WIDTH-1:0] digitT;

	localparam guideT guideNone = 2'b00;
	localparam guideT guideA = 2'b01;
	localparam guideT guideB = 2'b10;

	// highest cathode of a decade tube
	localparam digitT digitMax = 9;

endpackage

// ==== dekatron/DekatronPulseSender.sv ====
`timescale 1ns/1ps
`include "dekatron_config.svh"

module DekatronPulseSender
	import dekatron_pkg::*;
(
	input logic Clk,
	input logic hsClk,
	input logic Rst_n,
	input logic Step,
	input logic Dec,
	output guideT Pulses
);

	typedef enum logic [1:0] {
		stIdle,
		stFirst,
		stSecond
	} stateT;

	stateT state;
	logic stepSync;
	logic stepPrev;
	logic stepRise;

	// Step comes from the Clk domain, so it is edge-detected on hsClk
	always_ff @(posedge hsClk or negedge Rst_n) begin
		if (!Rst_n) begin
			stepSync <= 1'b0;
			stepPrev <= 1'b0;
		end else begin
			stepSync <= Step;
			stepPrev <= stepSync;
		end
	end

	assign stepRise = stepSync & ~stepPrev;

	always_ff @(posedge hsClk or negedge Rst_n) begin
		if (!Rst_n) begin
			state <= stIdle;
		end else begin
			case (state)
				stIdle: begin
					if (stepRise) begin
						state <= stFirst;
					end
				end
				stFirst: state <= stSecond;
				default: state <= stIdle;
			endcase
		end
	end

	// incrementing leads with guide A, decrementing leads with guide B
	always_comb begin
		case (state)
			stFirst: Pulses = Dec ? guideB : guideA;
			stSecond: Pulses = Dec ? guideA : guideB;
			default: Pulses = guideNone;
		endcase
	end

	// Step rises on a Clk edge, and the previous pair has to be over at that edge
	assert property (@(posedge Clk) disable iff (!Rst_n)
		$rose(Step) |-> ($past(state) == stIdle))
	else $error("Step rose while a guide pulse pair was still running");

	// the closing pulse is on the bus at the last hsClk edge of the step window
	assert property (@(posedge hsClk) disable iff (!Rst_n)
		$rose(Step) |-> ##(`DEK_STEP_CYCLES - 1) (state == stSecond))
	else $error("guide pulse pair not finished in time");

	assert property (@(posedge hsClk) disable iff (!Rst_n)
		!(Pulses[0] && Pulses[1]))
	else $error("both guides driven at once");

endmodule

// ==== dekatron/DekatronModule.sv ====
`timescale 1ns/1ps

module DekatronModule
	import dekatron_pkg::*;
(
	input logic hsClk,
	input logic Rst_n,
	input logic Load,
	input digitT In,
	input guideT Pulse,
	output digitT Out,
	output logic Zero,
	output logic CarryLow,
	output logic CarryHigh
);

	// glow position inside one cathode group
	// the tube has ten groups of main cathode, A guide and B guide, 30 positions in all
	localparam logic [1:0] phMain = 2'd0;
	localparam logic [1:0] phA = 2'd1;
	localparam logic [1:0] phB = 2'd2;

	digitT cathode;
	logic [1:0] phase;

	function automatic digitT nextDigit(input digitT d);
		nextDigit = (d == digitMax) ? digitT'(0) : digitT'(d + 1'b1);
	endfunction

	function automatic digitT prevDigit(input digitT d);
		prevDigit = (d == digitT'(0)) ? digitMax : digitT'(d - 1'b1);
	endfunction

	always_ff @(posedge hsClk or negedge Rst_n) begin
		if (!Rst_n) begin
			cathode <= '0;
			phase <= phMain;
		end else if (Load) begin
			cathode <= In;
			phase <= phMain;
		end else begin
			case (phase)
				phMain: begin
					// forward onto the A guide behind this cathode
					if (Pulse == guideA) begin
						phase <= phA;
					end else if (Pulse == guideB) begin
						// backward onto the B guide in front of the lower cathode
						cathode <= prevDigit(cathode);
						phase <= phB;
					end
				end
				phA: begin
					if (Pulse == guideB) begin
						cathode <= nextDigit(cathode);
						phase <= phMain;
					end
				end
				phB: begin
					if (Pulse == guideA) begin
						phase <= phMain;
					end
				end
				default: phase <= phMain;
			endcase
		end
	end

	// a guide with no matching neighbour leaves the glow in place, like the real tube

	assign Out = cathode;
	assign Zero = (cathode == digitT'(0)) && (phase == phMain);

	// both carry levels stay up across the whole wrapping step, so the next
	// decade receives both guide pulses of the pair
	assign CarryHigh = (cathode == digitMax);
	assign CarryLow = Zero || ((cathode == digitMax) && (phase != phMain));

	assert property (@(posedge hsClk) disable iff (!Rst_n)
		Load |-> (In <= digitMax))
	else $error("load value is not a BCD digit");

endmodule

// ==== dekatron/DekatronCounter.sv ====
`timescale 1ns/1ps
`include "dekatron_config.svh"

module DekatronCounter
	import dekatron_pkg::*;
(
	input logic Clk,
	input logic hsClk,
	input logic Rst_n,
	input logic Request,
	input logic Dec,
	input logic Set,
	input logic [`DEK_WIDTH-1:0] In,
	output logic Ready,
	output logic Zero,
	output logic [`DEK_WIDTH-1:0] Out
);

	localparam int digitWidth = `DEK_DIGIT_WIDTH;
	localparam logic [`DEK_COUNT_DELAY-1:0] settleFirst = 1'b1 << (`DEK_COUNT_DELAY - 1);

	logic busy;
	logic accept;
	logic [`DEK_COUNT_DELAY-1:0] settle;
	logic stepReq;
	logic loadReq;
	logic loadSeen;
	logic load;
	logic opDec;
	logic [`DEK_WIDTH-1:0] loadValue;
	logic [`DEK_DIGITS-1:0] zeroes;
	guideT senderPulses;
	guideT chain [`DEK_DIGITS];

	assign accept = Request && !busy;
	assign Ready = !busy;

	// a one-hot token walks down the settle shifter while the tubes settle
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			busy <= 1'b0;
			settle <= '0;
			stepReq <= 1'b0;
			loadReq <= 1'b0;
			opDec <= 1'b0;
		end else if (!busy) begin
			if (Request) begin
				busy <= 1'b1;
				settle <= settleFirst;
				stepReq <= !Set;
				loadReq <= Set;
				opDec <= Dec;
			end
		end else begin
			settle <= settle >> 1;
			if (settle[0]) begin
				busy <= 1'b0;
				stepReq <= 1'b0;
				loadReq <= 1'b0;
			end
		end
	end

	// In may change right after acceptance, the tubes load from this copy
	always_ff @(posedge Clk) begin
		if (accept && Set) begin
			loadValue <= In;
		end
	end

	// Load lasts from the rise of loadReq up to the next hsClk edge
	always_ff @(posedge hsClk or negedge Rst_n) begin
		if (!Rst_n) begin
			loadSeen <= 1'b0;
		end else begin
			loadSeen <= loadReq;
		end
	end

	assign load = loadReq && !loadSeen;

	DekatronPulseSender sender (
		.Clk(Clk),
		.hsClk(hsClk),
		.Rst_n(Rst_n),
		.Step(stepReq),
		.Dec(opDec),
		.Pulses(senderPulses)
	);

	assign chain[0] = senderPulses;

	for (genvar d = 0; d < `DEK_DIGITS; d++) begin : decade
		digitT digitOut;
		logic carryLow;
		logic carryHigh;

		DekatronModule tube (
			.hsClk(hsClk),
			.Rst_n(Rst_n),
			.Load(load),
			.In(loadValue[d*digitWidth +: digitWidth]),
			.Pulse(chain[d]),
			.Out(digitOut),
			.Zero(zeroes[d]),
			.CarryLow(carryLow),
			.CarryHigh(carryHigh)
		);

		assign Out[d*digitWidth +: digitWidth] = digitOut;

		// the top decade just wraps, its carry goes nowhere
		if (d < `DEK_DIGITS - 1) begin : forward
			assign chain[d+1] = ((carryHigh && !opDec) || (carryLow && opDec)) ?
				chain[d] : guideNone;
		end
	end

	assign Zero = &zeroes;

	assert property (@(posedge Clk) disable iff (!Rst_n)
		accept |=> (!Ready) [*`DEK_COUNT_DELAY] ##1 Ready)
	else $error("Ready low time differs from the settle delay");

endmodule

// ==== bench/DekatronCounterTb.sv ====
`timescale 1ns/1ps
`include "dekatron_config.svh"

module DekatronCounterTb;

	localparam int digitWidth = `DEK_DIGIT_WIDTH;
	localparam int readyTimeout = `DEK_COUNT_DELAY * 4 + 8;
	localparam logic [15:0] lfsrTaps = 16'hB400;

	logic Clk;
	logic hsClk;
	logic Rst_n;
	logic Request;
	logic Dec;
	logic Set;
	logic [`DEK_WIDTH-1:0] In;
	logic Ready;
	logic Zero;
	logic [`DEK_WIDTH-1:0] Out;

	int hsTicks;
	logic [15:0] lfsrState;
	int model;
	int modulus;
	int errorCount;
	int checkCount;
	int testCount;
	int testStartErrors;
	int lowCycles;

	// start values that end in runs of nines or zeros
	int incStarts [4] = '{99999, 9, 1299, 899999};
	int decStarts [4] = '{100000, 10, 5000, 200};

	DekatronCounter UUT (
		.Clk(Clk),
		.hsClk(hsClk),
		.Rst_n(Rst_n),
		.Request(Request),
		.Dec(Dec),
		.Set(Set),
		.In(In),
		.Ready(Ready),
		.Zero(Zero),
		.Out(Out)
	);

	// hsClk runs ten times faster, and every rising Clk edge meets a rising hsClk edge
	always begin
		#2;
		hsClk = ~hsClk;
		hsTicks = hsTicks + 1;
		if (hsTicks == 10) begin
			hsTicks = 0;
			Clk = ~Clk;
		end
	end

	always @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			lowCycles <= 0;
		end else if (!Ready) begin
			lowCycles <= lowCycles + 1;
		end else begin
			lowCycles <= 0;
		end
	end

	function automatic void reportError(input string msg);
		errorCount++;
		$display("Error at %0t ns: %s", $time, msg);
	endfunction

	assert property (@(posedge Clk) disable iff (!Rst_n)
		(Request && Ready) |=> !Ready)
	else reportError("Ready did not fall after an accepted request");

	assert property (@(posedge Clk) disable iff (!Rst_n)
		$rose(Ready) |-> (lowCycles == `DEK_COUNT_DELAY))
	else reportError("Ready returned after the wrong number of cycles");

	assert property (@(posedge Clk) disable iff (!Rst_n)
		!Ready |-> (lowCycles < `DEK_COUNT_DELAY))
	else reportError("Ready stayed low past the settle delay");

	assert property (@(posedge Clk) disable iff (!Rst_n)
		Ready |-> (Zero == (Out == '0)))
	else reportError("Zero disagrees with Out");

	// the LSB leaves the register at each step
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ lfsrTaps;
		end
		return n;
	endfunction

	task automatic drawBits(input int count, output int bits);
		bits = 0;
		for (int i = 0; i < count; i++) begin
			bits = (bits << 1) | int'(lfsrState[0]);
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	task automatic randomBcd(output int value);
		int nibble;
		value = 0;
		for (int i = 0; i < `DEK_DIGITS; i++) begin
			drawBits(4, nibble);
			value = value * 10 + (nibble % 10);
		end
	endtask

	function automatic logic [`DEK_WIDTH-1:0] toBcd(input int value);
		logic [`DEK_WIDTH-1:0] bcd;
		int rest;
		bcd = '0;
		rest = value;
		for (int i = 0; i < `DEK_DIGITS; i++) begin
			bcd[i*digitWidth +: digitWidth] = digitWidth'(rest % 10);
			rest = rest / 10;
		end
		return bcd;
	endfunction

	task automatic stopOnTimeout(input string what);
		errorCount++;
		$display("Timeout: Ready did not return while waiting %s", what);
		$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic waitForReady(input string what);
		int cycles;
		cycles = 0;
		while (!Ready && cycles < readyTimeout) begin
			@(posedge Clk);
			#2;
			cycles++;
		end
		if (!Ready) begin
			stopOnTimeout(what);
		end
	endtask

	task automatic checkCounter(input string label);
		checkCount++;
		assert (Out == toBcd(model))
		else reportError($sformatf("%s gave Out %h, expected %h", label, Out, toBcd(model)));
		checkCount++;
		assert (Zero == (model == 0))
		else reportError($sformatf("%s gave Zero %b for value %0d", label, Zero, model));
	endtask

	// one request, then the model follows the same decimal rule
	task automatic runRequest(input logic setOp, input logic decOp, input int value);
		waitForReady("before a request");
		Request = 1'b1;
		Set = setOp;
		Dec = decOp;
		In = toBcd(value);
		@(posedge Clk);
		#2;
		Request = 1'b0;
		In = '0;
		waitForReady("for a request to finish");
		if (setOp) begin
			model = value % modulus;
			checkCounter("load");
		end else if (decOp) begin
			model = (model + modulus - 1) % modulus;
			checkCounter("decrement");
		end else begin
			model = (model + 1) % modulus;
			checkCounter("increment");
		end
	endtask

	// Request stays high through the whole busy time and drops once Ready is back
	task automatic holdRequest(input logic decOp);
		int held;
		waitForReady("before a held request");
		Request = 1'b1;
		Set = 1'b0;
		Dec = decOp;
		@(posedge Clk);
		#2;
		held = 0;
		while (!Ready && held < readyTimeout) begin
			@(posedge Clk);
			#2;
			held++;
		end
		Request = 1'b0;
		if (!Ready) begin
			stopOnTimeout("during a held request");
		end else begin
			model = decOp ? (model + modulus - 1) % modulus : (model + 1) % modulus;
			checkCounter("held request");
			checkCount++;
			assert (held == `DEK_COUNT_DELAY)
			else reportError($sformatf("Ready low for %0d cycles", held));
		end
	endtask

	task automatic startTest();
		testStartErrors = errorCount;
	endtask

	task automatic endTest(input string name);
		testCount++;
		$display("test %0d %s finished with %0d errors", testCount, name,
			errorCount - testStartErrors);
	endtask

	initial begin
		int value;
		Clk = 1'b0;
		hsClk = 1'b1;
		hsTicks = 0;
		Rst_n = 1'b0;
		Request = 1'b0;
		Dec = 1'b0;
		Set = 1'b0;
		In = '0;
		lfsrState = 16'd26377;
		model = 0;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		modulus = 1;
		for (int i = 0; i < `DEK_DIGITS; i++) begin
			modulus = modulus * 10;
		end

		startTest();
		repeat (2) @(posedge Clk);
		#2;
		Rst_n = 1'b1;
		checkCount++;
		assert (Ready)
		else reportError("Ready low after reset");
		checkCounter("reset");
		endTest("reset state");

		startTest();
		runRequest(1'b1, 1'b0, 0);
		for (int n = 0; n < 6; n++) begin
			randomBcd(value);
			runRequest(1'b1, 1'b0, value);
		end
		endTest("load");

		startTest();
		for (int n = 0; n < 7; n++) begin
			if (n < 4) begin
				value = incStarts[n];
			end else begin
				randomBcd(value);
			end
			runRequest(1'b1, 1'b0, value);
			repeat (2) runRequest(1'b0, 1'b0, 0);
		end
		endTest("increment with ripple");

		startTest();
		for (int n = 0; n < 7; n++) begin
			if (n < 4) begin
				value = decStarts[n];
			end else begin
				randomBcd(value);
			end
			runRequest(1'b1, 1'b0, value);
			repeat (2) runRequest(1'b0, 1'b1, 0);
		end
		endTest("decrement with borrow");

		startTest();
		runRequest(1'b1, 1'b0, modulus - 1);
		runRequest(1'b0, 1'b0, 0);
		runRequest(1'b0, 1'b1, 0);
		endTest("wraparound");

		startTest();
		holdRequest(1'b0);
		holdRequest(1'b1);
		endTest("ready protocol");

		$display("tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+common
common/dekatron_pkg.sv
dekatron/DekatronPulseSender.sv
dekatron/DekatronModule.sv
dekatron/DekatronCounter.sv
bench/DekatronCounterTb.sv

// ==== Makefile ====
# Verilator build for the dekatron counter testbench

VERILATOR ?= verilator
TOP ?= DekatronCounterTb
FILELIST ?= build.f
OBJDIR ?= obj_dir
JOBS ?= 4
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL CHECKS PASSED

HEADERS := common/dekatron_config.svh
SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the output
run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)
